//--- hw/se_config.svh
`ifndef SE_CONFIG_SVH
`define SE_CONFIG_SVH

//////////////////////////////
// fixed-point format
//////////////////////////////
`define SE_DATA_W     14
`define SE_FBITS      9

//////////////////////////////
// layer geometry
//////////////////////////////
`define SE_LANES      4
`define SE_CHANNELS   16
`define SE_HIDDEN     4

// squeeze divider and weight memory
`define SE_DIVISOR_W  12
`define SE_ADDR_W     15
`define SE_DIV_CYCLES (`SE_DATA_W + 2)   // load, one cycle per bit, sign fix

`endif

//--- hw/se_pkg.sv
`default_nettype none

`include "se_config.svh"

package se_pkg;

    // one fixed-point sample, sign plus integer plus fraction
    typedef logic signed [`SE_DATA_W-1:0] data_t;

    typedef data_t [`SE_LANES-1:0] lane_vec_t;   // one beat of four lanes

    // headroom for the products summed over a whole neuron
    typedef logic signed [`SE_DATA_W+5:0] acc_t;

    typedef enum logic
    {
        LAYER_FC1 = 1'b0,   // relu layer
        LAYER_FC2 = 1'b1    // hard sigmoid layer
    } layer_t;

    typedef logic [`SE_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

//--- hw/se_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// one-cycle strobe with payload, no back-pressure
interface se_stream_if #(parameter type payload_t = logic);

    logic           valid;
    payload_t       payload;
    se_pkg::layer_t layer;     // which fc layer the beat belongs to
    logic           last;      // closes a neuron or a layer

    modport producer (output valid, output payload, output layer, output last);
    modport consumer (input valid, input payload, input layer, input last);

endinterface

`default_nettype wire

//--- hw/lane_divider.sv
`timescale 1ns/100ps
`default_nettype none

`include "se_config.svh"

module lane_divider (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  se_pkg::lane_vec_t        dividends,
    input  logic [`SE_DIVISOR_W-1:0] divisor,
    output logic                     busy,
    output logic                     div_done,
    output se_pkg::lane_vec_t        quotients
);

    localparam int W         = `SE_DATA_W;
    localparam int DW        = `SE_DIVISOR_W;
    localparam int LAST_STEP = `SE_DIV_CYCLES - 2;   // iterations before the sign fix

    logic [$clog2(LAST_STEP+1)-1:0] step;
    logic [DW-1:0]                  dvsr;
    logic [`SE_LANES-1:0]           neg;    // sign of each dividend
    logic [W-1:0]                   quo     [`SE_LANES];
    logic [DW-1:0]                  rem     [`SE_LANES];
    logic [W-1:0]                   quo_nxt [`SE_LANES];
    logic [DW-1:0]                  rem_nxt [`SE_LANES];
    logic                           load;

    assign load = start && !busy;   // start is dropped while a division runs

    //////////////////////////////
    // restoring step, all lanes
    //////////////////////////////
    always_comb
    begin
        logic [DW:0]   shifted;
        logic [DW+1:0] diff;

        for (int i = 0; i < `SE_LANES; i++)
        begin
            shifted = {rem[i], quo[i][W-1]};           // bring down next dividend bit
            diff    = {1'b0, shifted} - {2'b00, dvsr};
            if (!diff[DW+1])
            begin
                rem_nxt[i] = diff[DW-1:0];
                quo_nxt[i] = {quo[i][W-2:0], 1'b1};
            end
            else
            begin
                rem_nxt[i] = shifted[DW-1:0];            // restore
                quo_nxt[i] = {quo[i][W-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            busy     <= 1'b0;
            div_done <= 1'b0;
            step     <= '0;
        end
        else
        begin
            div_done <= 1'b0;
            if (load)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (step == LAST_STEP)
                begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    // datapath works on magnitudes, quotient register doubles as shifted dividend
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            dvsr <= divisor;
            for (int i = 0; i < `SE_LANES; i++)
            begin
                neg[i] <= dividends[i][W-1];
                quo[i] <= dividends[i][W-1] ? W'(-dividends[i]) : W'(dividends[i]);
                rem[i] <= '0;
            end
        end
        else if (busy && step != LAST_STEP)
        begin
            for (int i = 0; i < `SE_LANES; i++)
            begin
                quo[i] <= quo_nxt[i];
                rem[i] <= rem_nxt[i];
            end
        end
        else if (busy)
        begin
            for (int i = 0; i < `SE_LANES; i++)
                quotients[i] <= neg[i] ? se_pkg::data_t'(-quo[i]) : se_pkg::data_t'(quo[i]);
        end
    end

endmodule

`default_nettype wire

//--- hw/activation_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "se_config.svh"

module activation_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  se_pkg::layer_t in_layer,
    input  se_pkg::acc_t   in_sum,
    se_stream_if.producer  res_bus
);

    localparam se_pkg::acc_t DATA_MAX = (1 <<< (`SE_DATA_W - 1)) - 1;
    localparam se_pkg::acc_t HALF     = 1 <<< (`SE_FBITS - 1);
    localparam se_pkg::acc_t ONE      = 1 <<< `SE_FBITS;
    localparam int           CNT_W    = $clog2(`SE_CHANNELS);

    se_pkg::acc_t   shifted;
    se_pkg::data_t  act;
    logic [CNT_W-1:0] neuron;   // outputs seen in the current layer
    logic           final_neuron;

    always_comb
    begin
        shifted = (in_sum >>> 2) + HALF;   // x/4 + 0.5
        if (in_layer == se_pkg::LAYER_FC1)
        begin
            if (in_sum < 0)
                act = '0;
            else if (in_sum > DATA_MAX)
                act = se_pkg::data_t'(DATA_MAX);
            else
                act = se_pkg::data_t'(in_sum);
        end
        else
        begin
            if (shifted < 0)
                act = '0;
            else if (shifted > ONE)
                act = se_pkg::data_t'(ONE);
            else
                act = se_pkg::data_t'(shifted);
        end
    end

    assign final_neuron = (in_layer == se_pkg::LAYER_FC1) ?
                          (neuron == CNT_W'(`SE_HIDDEN - 1)) :
                          (neuron == CNT_W'(`SE_CHANNELS - 1));

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            res_bus.valid <= 1'b0;
            neuron        <= '0;
        end
        else
        begin
            res_bus.valid <= in_valid;
            if (in_valid)
                neuron <= final_neuron ? '0 : neuron + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            res_bus.payload <= act;
            res_bus.layer   <= in_layer;
            res_bus.last    <= final_neuron;
        end
    end

endmodule

`default_nettype wire

//--- hw/dot_product.sv
`timescale 1ns/100ps
`default_nettype none

`include "se_config.svh"

module dot_product (
    input  logic              clk,
    input  logic              rst,
    input  se_pkg::lane_vec_t weights,
    se_stream_if.consumer     op_bus,
    se_stream_if.producer     res_bus
);

    localparam int W = `SE_DATA_W;

    logic signed [2*W-1:0] full [`SE_LANES];   // raw products
    se_pkg::acc_t          prod [`SE_LANES];   // rescaled, registered
    logic                  mul_valid;
    logic                  mul_last;
    se_pkg::layer_t        mul_layer;
    se_pkg::acc_t          tree_sum;
    se_pkg::acc_t          acc;
    se_pkg::acc_t          sum;
    logic                  sum_valid;
    se_pkg::layer_t        sum_layer;

    always_comb
    begin
        for (int i = 0; i < `SE_LANES; i++)
            full[i] = op_bus.payload[i] * weights[i];
    end

    //////////////////////////////
    // multiply register
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (op_bus.valid)
        begin
            for (int i = 0; i < `SE_LANES; i++)
                prod[i] <= se_pkg::acc_t'(full[i] >>> `SE_FBITS);
            mul_last  <= op_bus.last;
            mul_layer <= op_bus.layer;
        end
    end

    // adder tree over the lanes
    always_comb
    begin
        tree_sum = '0;
        for (int i = 0; i < `SE_LANES; i++)
            tree_sum = tree_sum + prod[i];
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            mul_valid <= 1'b0;
            sum_valid <= 1'b0;
            acc       <= '0;
        end
        else
        begin
            mul_valid <= op_bus.valid;
            sum_valid <= mul_valid && mul_last;        // one strobe per neuron
            if (mul_valid)
                acc <= mul_last ? '0 : acc + tree_sum;  // restart after last step
        end
    end

    always_ff @(posedge clk)
    begin
        if (mul_valid && mul_last)
        begin
            sum       <= acc + tree_sum;
            sum_layer <= mul_layer;
        end
    end

    activation_unit act_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (sum_valid),
        .in_layer (sum_layer),
        .in_sum   (sum),
        .res_bus  (res_bus)
    );

endmodule

`default_nettype wire

//--- hw/fc_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "se_config.svh"

module fc_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              se_start,
    input  se_pkg::addr_t     fc1_base,
    input  se_pkg::addr_t     fc2_base,
    input  logic              div_done,
    input  se_pkg::lane_vec_t quotients,
    output logic              weight_rd,
    output se_pkg::addr_t     weight_addr,
    se_stream_if.producer     op_bus,
    se_stream_if.consumer     res_bus,
    output logic              scale_valid,
    output logic              se_done,
    output se_pkg::lane_vec_t scale_data
);

    localparam int LANES     = `SE_LANES;
    localparam int GROUPS    = `SE_CHANNELS / LANES;   // also fc1 steps per neuron
    localparam int FC1_READS = `SE_HIDDEN * GROUPS;
    localparam int FC2_READS = `SE_CHANNELS;
    localparam int IDX_W     = $clog2(`SE_CHANNELS);
    localparam int GRP_W     = $clog2(GROUPS);
    localparam int HID_W     = $clog2(`SE_HIDDEN);

    se_pkg::data_t    chan   [`SE_CHANNELS];   // averages, later the scales
    se_pkg::data_t    hidden [`SE_HIDDEN];
    se_pkg::addr_t    fc1_base_r;
    se_pkg::addr_t    fc2_base_r;
    logic [GRP_W-1:0] grp;        // squeeze group being filled
    logic             run;        // weight reads in progress
    se_pkg::layer_t   layer;
    logic [IDX_W-1:0] rd_idx;
    logic [GRP_W-1:0] step;
    logic             rd_final;
    logic [IDX_W-1:0] wr_idx;
    logic             fc1_end;
    logic             fc2_end;
    logic             out_run;
    logic [GRP_W-1:0] out_grp;

    assign step     = rd_idx[GRP_W-1:0];   // low bits pick the channel group
    assign rd_final = (layer == se_pkg::LAYER_FC1) ? (rd_idx == IDX_W'(FC1_READS - 1)) :
                                                     (rd_idx == IDX_W'(FC2_READS - 1));
    assign fc1_end  = res_bus.valid && res_bus.last && res_bus.layer == se_pkg::LAYER_FC1;
    assign fc2_end  = res_bus.valid && res_bus.last && res_bus.layer == se_pkg::LAYER_FC2;

    //////////////////////////////
    // sequencing
    //////////////////////////////
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            fc1_base_r <= '0;
            fc2_base_r <= '0;
            grp        <= '0;
            run        <= 1'b0;
            layer      <= se_pkg::LAYER_FC1;
            rd_idx     <= '0;
            wr_idx     <= '0;
            out_run    <= 1'b0;
            out_grp    <= '0;
        end
        else
        begin
            if (se_start)
            begin
                fc1_base_r <= fc1_base;
                fc2_base_r <= fc2_base;
                grp        <= '0;
            end
            else if (div_done)
                grp <= grp + 1'b1;

            if (div_done && grp == GRP_W'(GROUPS - 1))
            begin
                run    <= 1'b1;   // all averages stored
                layer  <= se_pkg::LAYER_FC1;
                rd_idx <= '0;
            end
            else if (fc1_end)
            begin
                run    <= 1'b1;
                layer  <= se_pkg::LAYER_FC2;
                rd_idx <= '0;
            end
            else if (run)
            begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_final)
                    run <= 1'b0;
            end

            if (res_bus.valid)
                wr_idx <= res_bus.last ? '0 : wr_idx + 1'b1;

            if (fc2_end)
            begin
                out_run <= 1'b1;
                out_grp <= '0;
            end
            else if (out_run)
            begin
                out_grp <= out_grp + 1'b1;
                if (out_grp == GRP_W'(GROUPS - 1))
                    out_run <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // stores
    //////////////////////////////
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < `SE_CHANNELS; i++)
                chan[i] <= '0;
            for (int i = 0; i < `SE_HIDDEN; i++)
                hidden[i] <= '0;
        end
        else
        begin
            if (div_done)
            begin
                for (int i = 0; i < LANES; i++)
                    chan[grp * LANES + i] <= quotients[i];
            end
            else if (res_bus.valid && res_bus.layer == se_pkg::LAYER_FC2)
                chan[wr_idx] <= res_bus.payload;   // scale overwrites its average

            if (res_bus.valid && res_bus.layer == se_pkg::LAYER_FC1)
                hidden[wr_idx[HID_W-1:0]] <= res_bus.payload;
        end
    end

    // operand beat lines up with the weight word one cycle after the read
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            op_bus.valid <= 1'b0;
        else
            op_bus.valid <= run;
    end

    always_ff @(posedge clk)
    begin
        if (run)
        begin
            op_bus.layer <= layer;
            op_bus.last  <= (layer == se_pkg::LAYER_FC2) || (step == GRP_W'(GROUPS - 1));
            for (int i = 0; i < LANES; i++)   // fc2 takes every hidden value at once
                op_bus.payload[i] <= (layer == se_pkg::LAYER_FC1) ? chan[step * LANES + i] :
                                                                    hidden[i];
        end
    end

    assign weight_rd   = run;
    assign weight_addr = ((layer == se_pkg::LAYER_FC1) ? fc1_base_r : fc2_base_r) +
                         se_pkg::addr_t'(rd_idx);

    // scale read-out
    assign scale_valid = out_run;
    assign se_done     = out_run && out_grp == GRP_W'(GROUPS - 1);

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
            scale_data[i] = chan[out_grp * LANES + i];
    end

endmodule

`default_nettype wire

//--- hw/se_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "se_config.svh"

module se_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     se_start,
    input  logic                     sum_valid,
    input  se_pkg::lane_vec_t        lane_sums,
    input  logic [`SE_DIVISOR_W-1:0] divisor,
    input  se_pkg::addr_t            fc1_base,
    input  se_pkg::addr_t            fc2_base,
    input  se_pkg::lane_vec_t        weight_data,
    output logic                     busy,
    output logic                     weight_rd,
    output logic                     scale_valid,
    output logic                     se_done,
    output se_pkg::addr_t            weight_addr,
    output se_pkg::lane_vec_t        scale_data
);

    logic              div_done;
    se_pkg::lane_vec_t quotients;

    se_stream_if #(.payload_t(se_pkg::lane_vec_t)) op_bus ();   // sequencer to multipliers
    se_stream_if #(.payload_t(se_pkg::data_t))     res_bus ();  // activated neurons back

    // squeeze
    lane_divider div_i (
        .clk       (clk),
        .rst       (rst),
        .start     (sum_valid),
        .dividends (lane_sums),
        .divisor   (divisor),
        .busy      (busy),
        .div_done  (div_done),
        .quotients (quotients)
    );

    // excitation arithmetic
    dot_product dot_i (
        .clk     (clk),
        .rst     (rst),
        .weights (weight_data),
        .op_bus  (op_bus),
        .res_bus (res_bus)
    );

    fc_sequencer seq_i (
        .clk         (clk),
        .rst         (rst),
        .se_start    (se_start),
        .fc1_base    (fc1_base),
        .fc2_base    (fc2_base),
        .div_done    (div_done),
        .quotients   (quotients),
        .weight_rd   (weight_rd),
        .weight_addr (weight_addr),
        .op_bus      (op_bus),
        .res_bus     (res_bus),
        .scale_valid (scale_valid),
        .se_done     (se_done),
        .scale_data  (scale_data)
    );

endmodule

`default_nettype wire

//--- verification/se_tests.svh
`ifndef SE_TESTS_SVH
`define SE_TESTS_SVH

//////////////////////////////
// reference model
//////////////////////////////
function automatic int scaled_product(int a, int w);
    return (a * w) >>> `SE_FBITS;
endfunction

function automatic int relu(int x);
    if (x < 0)
        return 0;
    if (x > 8191)
        return 8191;   // largest data_t
    return x;
endfunction

function automatic int hard_sigmoid(int x);
    int y;
    y = (x >>> 2) + 256;
    if (y < 0)
        return 0;
    if (y > 512)
        return 512;
    return y;
endfunction

function automatic void build_model(se_pkg::addr_t b1, se_pkg::addr_t b2);
    int q [`SE_CHANNELS];
    int hid [`SE_HIDDEN];
    int acc;
    for (int c = 0; c < `SE_CHANNELS; c++)
        q[c] = sums[c] / divs[c / `SE_LANES];   // int division truncates toward zero
    for (int h = 0; h < `SE_HIDDEN; h++)
    begin
        acc = 0;
        for (int s = 0; s < GROUPS; s++)
            for (int i = 0; i < `SE_LANES; i++)
                acc += scaled_product(q[4*s+i], int'(wmem[b1 + 4*h + s][i]));
        hid[h] = relu(acc);
    end
    for (int c = 0; c < `SE_CHANNELS; c++)
    begin
        acc = 0;
        for (int i = 0; i < `SE_LANES; i++)
            acc += scaled_product(hid[i], int'(wmem[b2 + c][i]));
        exp_scale[c] = hard_sigmoid(acc);
    end
endfunction

//////////////////////////////
// stimulus helpers
//////////////////////////////
task automatic drive_group(int g);
    sum_valid = 1'b1;
    divisor   = divs[g][`SE_DIVISOR_W-1:0];
    for (int i = 0; i < `SE_LANES; i++)
        lane_sums[i] = se_pkg::data_t'(sums[g * `SE_LANES + i]);
endtask

task automatic start_run(se_pkg::addr_t b1, se_pkg::addr_t b2);
    @(posedge clk);
    #2;
    se_start = 1'b1;
    fc1_base = b1;
    fc2_base = b2;
    @(posedge clk);
    #2 se_start = 1'b0;
endtask

task automatic send_group(int g);
    int n;
    @(posedge clk);
    #2 drive_group(g);
    @(posedge clk);
    #2 sum_valid = 1'b0;
    n = 0;
    do
    begin
        @(posedge clk);
        #1 n++;
        if (n > 40)
            abort_run("busy never fell after a squeeze group");
    end
    while (busy);
endtask

task automatic fill_random(se_pkg::addr_t b1, se_pkg::addr_t b2);
    for (int c = 0; c < `SE_CHANNELS; c++)
        sums[c] = int'($urandom_range(16000)) - 8000;
    for (int g = 0; g < GROUPS; g++)
        divs[g] = int'($urandom_range(63, 4));
    for (int k = 0; k < 16; k++)
        for (int i = 0; i < `SE_LANES; i++)
        begin
            wmem[b1 + k][i] = se_pkg::data_t'(int'($urandom_range(600)) - 300);
            wmem[b2 + k][i] = se_pkg::data_t'(int'($urandom_range(600)) - 300);
        end
endtask

// sixteen back-to-back reads from base upward
task automatic check_reads(se_pkg::addr_t base, string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!weight_rd)
    begin
        n++;
        if (n > 100)
            abort_run({"no weight reads came for ", name});
        @(negedge clk);
    end
    for (int k = 0; k < 16; k++)
    begin
        check_flag("weight_rd", 1'b1, weight_rd);
        check_addr(name, se_pkg::addr_t'(base + k), weight_addr);
        @(negedge clk);
    end
    check_flag("weight_rd", 1'b0, weight_rd);   // no seventeenth read
endtask

task automatic check_scales();
    se_pkg::lane_vec_t e;
    int                n;
    n = 0;
    while (!scale_valid)
    begin
        n++;
        if (n > 200)
            abort_run("scale_valid never rose");
        @(negedge clk);
    end
    for (int b = 0; b < GROUPS; b++)
    begin
        for (int i = 0; i < `SE_LANES; i++)
            e[i] = se_pkg::data_t'(exp_scale[b * `SE_LANES + i]);
        check_flag("scale_valid", 1'b1, scale_valid);
        check_vec("scale_data", e, scale_data);
        check_flag("se_done", b == GROUPS - 1, se_done);
        @(negedge clk);
    end
    check_flag("scale_valid", 1'b0, scale_valid);
    check_flag("se_done", 1'b0, se_done);
endtask

task automatic full_run(se_pkg::addr_t b1, se_pkg::addr_t b2);
    build_model(b1, b2);
    start_run(b1, b2);
    for (int g = 0; g < GROUPS; g++)
        send_group(g);
    check_reads(b1, "weight_addr fc1");
    check_reads(b2, "weight_addr fc2");
    check_scales();
endtask

//////////////////////////////
// directed tests
//////////////////////////////
task automatic test_reset_values();
    @(negedge clk);
    check_flag("busy", 1'b0, busy);
    check_flag("weight_rd", 1'b0, weight_rd);
    check_flag("scale_valid", 1'b0, scale_valid);
    check_flag("se_done", 1'b0, se_done);
    check_vec("scale_data", '0, scale_data);   // channel store cleared
endtask

task automatic test_divider_timing();
    se_pkg::addr_t b1;
    se_pkg::addr_t b2;
    int            n;
    b1 = 100;
    b2 = 2000;
    fill_random(b1, b2);
    build_model(b1, b2);
    start_run(b1, b2);

    @(posedge clk);
    #2 drive_group(0);
    n = 0;
    do
    begin
        @(posedge clk);
        #1 n++;
        if (n > 40)
            abort_run("busy never fell in the divider timing test");
        if (busy)
        begin
            #1;
            if (n == 1)
                sum_valid = 1'b0;
            else if (n == 4)
            begin
                sum_valid = 1'b1;              // must be ignored
                lane_sums = {4{se_pkg::data_t'(1234)}};
            end
            else if (n == 5)
                sum_valid = 1'b0;
        end
    end
    while (busy);
    check_data("busy cycles", se_pkg::data_t'(`SE_DIV_CYCLES), se_pkg::data_t'(n));

    send_group(1);
    send_group(2);
    for (int k = 0; k < 20; k++)   // only three groups counted so far
    begin
        @(negedge clk);
        check_flag("weight_rd", 1'b0, weight_rd);
    end
    send_group(3);
    check_reads(b1, "weight_addr fc1");
    check_reads(b2, "weight_addr fc2");
    check_scales();
endtask

task automatic test_end_to_end();
    se_pkg::addr_t b1;
    se_pkg::addr_t b2;
    b1 = se_pkg::addr_t'($urandom_range(8000, 4000));
    b2 = se_pkg::addr_t'($urandom_range(20000, 12000));
    fill_random(b1, b2);
    full_run(b1, b2);
endtask

task automatic test_saturation();
    for (int c = 0; c < `SE_CHANNELS; c++)
        sums[c] = 4000;
    for (int g = 0; g < GROUPS; g++)
        divs[g] = 1;
    for (int k = 0; k < 16; k++)
        for (int i = 0; i < `SE_LANES; i++)
        begin
            wmem[300 + k][i] = se_pkg::data_t'(1024);                  // weight 2.0
            wmem[600 + k][i] = se_pkg::data_t'((k % 2 == 0) ? 512 : -512);
        end
    full_run(300, 600);
endtask

task automatic test_back_to_back();
    fill_random(1000, 1100);
    full_run(1000, 1100);
    fill_random(30000, 31000);   // new bases and data right after the first run
    full_run(30000, 31000);
endtask

`endif

//--- verification/se_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "se_config.svh"

module se_tb;

    localparam int GROUPS = `SE_CHANNELS / `SE_LANES;
    localparam int WORDS  = 1 << `SE_ADDR_W;

    logic                     clk;
    logic                     rst;
    logic                     se_start;
    logic                     sum_valid;
    se_pkg::lane_vec_t        lane_sums;
    logic [`SE_DIVISOR_W-1:0] divisor;
    se_pkg::addr_t            fc1_base;
    se_pkg::addr_t            fc2_base;
    se_pkg::lane_vec_t        weight_data;
    logic                     busy;
    logic                     weight_rd;
    logic                     scale_valid;
    logic                     se_done;
    se_pkg::addr_t            weight_addr;
    se_pkg::lane_vec_t        scale_data;

    se_pkg::lane_vec_t wmem [WORDS];           // weight memory model
    int                sums [`SE_CHANNELS];    // squeeze inputs of the current run
    int                divs [GROUPS];
    int                exp_scale [`SE_CHANNELS];
    int                errors;
    int                timeouts;
    logic              rd_seen;
    se_pkg::addr_t     rd_addr;

    always #10 clk = ~clk;

    se_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .se_start    (se_start),
        .sum_valid   (sum_valid),
        .lane_sums   (lane_sums),
        .divisor     (divisor),
        .fc1_base    (fc1_base),
        .fc2_base    (fc2_base),
        .weight_data (weight_data),
        .busy        (busy),
        .weight_rd   (weight_rd),
        .scale_valid (scale_valid),
        .se_done     (se_done),
        .weight_addr (weight_addr),
        .scale_data  (scale_data)
    );

    //////////////////////////////
    // weight memory, one cycle read latency
    //////////////////////////////
    always @(negedge clk)
    begin
        rd_seen <= weight_rd;     // mid-cycle, away from the edge
        rd_addr <= weight_addr;
    end

    always @(posedge clk)
    begin
        #2;
        if (rd_seen)
            weight_data = wmem[rd_addr];
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_data(string name, se_pkg::data_t exp, se_pkg::data_t act);
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_vec(string name, se_pkg::lane_vec_t exp, se_pkg::lane_vec_t act);
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(string name, se_pkg::addr_t exp, se_pkg::addr_t act);
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // a wait that ran out ends the run here
    task automatic abort_run(string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        $display("Errors found");
        $finish;
    endtask

    `include "se_tests.svh"

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b0;
        se_start    = 1'b0;
        sum_valid   = 1'b0;
        lane_sums   = '0;
        divisor     = '0;
        fc1_base    = '0;
        fc2_base    = '0;
        weight_data = '0;
        errors      = 0;
        timeouts    = 0;
        void'($urandom(39388));

        // background pattern, depends on every address bit
        for (int a = 0; a < WORDS; a++)
            for (int i = 0; i < `SE_LANES; i++)
                wmem[a][i] = se_pkg::data_t'((a * 13 + (a >> 4) * 7 + i * 3) % 97 - 48);

        repeat (8) @(posedge clk);
        #2 rst = 1'b1;

        test_reset_values();
        test_divider_timing();
        test_end_to_end();
        test_saturation();
        test_back_to_back();

        repeat (4) @(posedge clk);
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
+incdir+verification
hw/se_pkg.sv
hw/se_stream_if.sv
hw/lane_divider.sv
hw/activation_unit.sv
hw/dot_product.sv
hw/fc_sequencer.sv
hw/se_top.sv
verification/se_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= se_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
